/* aes256_dec.f */
+incdir+src
src/aes_pkg.sv
src/inv_sbox.sv
src/dec_round_ctrl.sv
src/dec_state_path.sv
src/aes256_dec.sv
dv/aes256_dec_sva.sv
dv/tb_aes256_dec.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the aes256_dec testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_aes256_dec \
    -f aes256_dec.f --Mdir obj_dir -o sim_aes256_dec; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_aes256_dec > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

/* dv/round_keys.hex */
// AES-256 round keys for cipher key 000102..1f, one 128-bit key per line
// line n holds round key n, the word returned for key_addr n
000102030405060708090a0b0c0d0e0f
101112131415161718191a1b1c1d1e1f
a573c29fa176c498a97fce93a572c09c
1651a8cd0244beda1a5da4c10640bade
ae87dff00ff11b68a68ed5fb03fc1567
6de1f1486fa54f9275f8eb5373b8518d
c656827fc9a799176f294cec6cd5598b
3de23a75524775e727bf9eb45407cf39
0bdc905fc27b0948ad5245a4c1871c2f
45f5a66017b2d387300d4d33640a820a
7ccff71cbeb4fe5413e6bbf0d261a7df
f01afafee7a82979d7a5644ab3afe640
2541fe719bf500258813bbd55a721c0a
4e5a6699a9f24fe07e572baacdf8cdea
24fc79ccbf0979e9371ac23c6d68de36

/* dv/tb_aes256_dec.sv */
// tb_aes256_dec: clock, reset, round key store, stimulus table, compare tasks and timeouts
`timescale 1ns/1ps
`include "aes_defs.svh"

module tb_aes256_dec
    import aes_pkg::*;
();

    localparam int TIMEOUT_CYCLES  = 400;
    // done is seen in the cycle after edge 266 counted from the start edge
    localparam int DONE_CYCLE      = 266;
    localparam int ROUND_CYCLES    = 19;
    localparam int MID_START_CYCLE = 100;
    localparam int NUM_ROWS        = 6;

    // FIPS-197 C.3 vector
    localparam logic [127:0] C3_CIPHER = 128'h8ea2b7ca516745bfeafc49904b496089;
    localparam logic [127:0] C3_PLAIN  = 128'h00112233445566778899aabbccddeeff;

    typedef struct packed
    {
        logic [127:0] cipher;
        logic [127:0] plain;
        logic [7:0]   gap;
        logic         rand_gap;
        logic         mid_start;
    } stim_row_t;

    logic                          clk;
    logic                          resetn;
    dec_in_t                       dec_in;
    logic [`AES_BLOCK_BITS-1:0]    round_key;
    dec_out_t                      dec_out;
    logic [`AES_KEY_ADDR_BITS-1:0] key_addr;

    logic [`AES_BLOCK_BITS-1:0]    key_mem [0:`AES_ROUNDS];
    stim_row_t                     stim_rows [0:NUM_ROWS-1];
    // plaintext that must hold between done pulses
    logic [`AES_BLOCK_BITS-1:0]    held_block;
    integer                        seed;

    aes256_dec u_aes256_dec (
        .clk       (clk),
        .resetn    (resetn),
        .dec_in    (dec_in),
        .round_key (round_key),
        .dec_out   (dec_out),
        .key_addr  (key_addr)
    );

    // key store answers in the same cycle
    assign round_key = key_mem[key_addr];

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_block(input string name, input aes_state_u got, input aes_state_u exp);
        if (got.block !== exp.block)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got.block, exp.block);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [`AES_KEY_ADDR_BITS-1:0] got,
                              input logic [`AES_KEY_ADDR_BITS-1:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // round r lasts 19 cycles from 13 down, then back to 14
    function automatic logic [`AES_KEY_ADDR_BITS-1:0] expected_addr(input int k);
        if (k < DONE_CYCLE)
            return 4'(`AES_ROUNDS - 1 - k / ROUND_CYCLES);
        return 4'(`AES_ROUNDS);
    endfunction

    // idle cycles, sampled on the falling edge
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            check_bit("dec_out.done", dec_out.done, 1'b0);
            check_addr("key_addr", key_addr, 4'(`AES_ROUNDS));
            check_block("dec_out.block", dec_out.block, held_block);
        end
    endtask

    // start sampled on the next rising edge, then wait for done
    task automatic run_block(input stim_row_t row);
        int   k;
        logic seen;
        k            = 0;
        seen         = 1'b0;
        dec_in.start = 1'b1;
        dec_in.block = row.cipher;
        while (!seen && k < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            check_addr("key_addr", key_addr, expected_addr(k));
            if (dec_out.done)
                seen = 1'b1;
            else
            begin
                check_block("dec_out.block", dec_out.block, held_block);
                k++;
            end
            // stray start with a wrong block while busy
            dec_in.start = row.mid_start && (k == MID_START_CYCLE);
            dec_in.block = (k == MID_START_CYCLE) ? ~row.cipher : row.cipher;
        end
        if (!seen)
        begin
            $display("timeout: done never arrived within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
        if (k != DONE_CYCLE)
        begin
            $display("done arrived %0d edges after the start edge, not %0d", k + 1,
                     DONE_CYCLE + 1);
            stop_run();
        end
        check_block("dec_out.block", dec_out.block, row.plain);
        held_block = row.plain;
    endtask

    initial
    begin
        int gap;
        seed       = 32'ha787fd4f;
        resetn     = 1'b0;
        dec_in     = '0;
        held_block = '0;
        $readmemh("dv/round_keys.hex", key_mem);
        // gap, random gap, mid-run start
        stim_rows[0] = '{C3_CIPHER, C3_PLAIN, 8'd2, 1'b0, 1'b0};
        stim_rows[1] = '{C3_CIPHER, C3_PLAIN, 8'd0, 1'b0, 1'b1};
        stim_rows[2] = '{C3_CIPHER, C3_PLAIN, 8'd0, 1'b0, 1'b0};
        stim_rows[3] = '{C3_CIPHER, C3_PLAIN, 8'd0, 1'b1, 1'b0};
        stim_rows[4] = '{C3_CIPHER, C3_PLAIN, 8'd0, 1'b1, 1'b1};
        stim_rows[5] = '{C3_CIPHER, C3_PLAIN, 8'd0, 1'b1, 1'b0};
        if ($isunknown(key_mem[0]) || $isunknown(key_mem[`AES_ROUNDS]))
        begin
            $display("round key file dv/round_keys.hex did not load");
            stop_run();
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // reset values
        check_bit("dec_out.done", dec_out.done, 1'b0);
        check_addr("key_addr", key_addr, 4'(`AES_ROUNDS));
        check_block("dec_out.block", dec_out.block, '0);
        for (int i = 0; i < NUM_ROWS; i++)
        begin
            // gap 0 means start on the done cycle
            if (stim_rows[i].rand_gap)
                gap = 1 + ($unsigned($random(seed)) % 8);
            else
                gap = stim_rows[i].gap;
            idle_cycles(gap);
            run_block(stim_rows[i]);
        end
        // done drops after one cycle, block holds
        idle_cycles(3);
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* dv/aes256_dec_sva.sv */
// aes256_dec_sva: concurrent checks on the done strobe and key address, bound to aes256_dec
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes256_dec_sva
(
    input logic                          clk,
    input logic                          resetn,
    input logic                          done,
    input logic [`AES_KEY_ADDR_BITS-1:0] key_addr
);

    // done is a one-cycle strobe
    a_done_single: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done high on two cycles in a row");

    // only round keys 0..14 exist
    a_addr_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= `AES_ROUNDS)
        else $error("key_addr points past the last round key");

    // done follows the round 0 key addition
    a_done_after_key0: assert property (@(posedge clk) disable iff (!resetn)
        done |-> ($past(key_addr) == 4'd0))
        else $error("done without key_addr 0 on the cycle before");

endmodule

bind aes256_dec aes256_dec_sva u_sva (
    .clk      (clk),
    .resetn   (resetn),
    .done     (dec_out.done),
    .key_addr (key_addr)
);

/* src/aes256_dec.sv */
// aes256_dec: top level joining the round controller, state datapath and inverse S-box
`timescale 1ns/1ps
`include "aes_defs.svh"

module aes256_dec
    import aes_pkg::*;
(
    input  logic                          clk,
    input  logic                          resetn,
    input  dec_in_t                       dec_in,
    input  logic [`AES_BLOCK_BITS-1:0]    round_key,
    output dec_out_t                      dec_out,
    output logic [`AES_KEY_ADDR_BITS-1:0] key_addr
);

    path_ctrl_t                 path_ctrl;
    logic [7:0]                 sbox_in;
    logic [7:0]                 sbox_out;
    logic                       done;
    logic [`AES_BLOCK_BITS-1:0] plain_block;

    // round sequencing and key index
    dec_round_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .start     (dec_in.start),
        .key_addr  (key_addr),
        .path_ctrl (path_ctrl),
        .done      (done)
    );

    // block state, key addition, shift rows, mix columns
    dec_state_path u_path (
        .clk       (clk),
        .resetn    (resetn),
        .ctrl      (path_ctrl),
        .cipher_in (dec_in.block),
        .round_key (round_key),
        .sbox_in   (sbox_in),
        .sbox_out  (sbox_out),
        .plain_out (plain_block)
    );

    // one byte per cycle, one cycle latency
    inv_sbox u_sbox (
        .clk      (clk),
        .resetn   (resetn),
        .byte_in  (sbox_in),
        .byte_out (sbox_out)
    );

    assign dec_out.done  = done;
    assign dec_out.block = plain_block;

endmodule

/* src/dec_state_path.sv */
// dec_state_path: block state register with load, inv shift rows, byte write-back, key add, inv mix
`timescale 1ns/1ps
`include "aes_defs.svh"

module dec_state_path
    import aes_pkg::*;
(
    input  logic                       clk,
    input  logic                       resetn,
    input  path_ctrl_t                 ctrl,
    input  logic [`AES_BLOCK_BITS-1:0] cipher_in,
    input  logic [`AES_BLOCK_BITS-1:0] round_key,
    output logic [7:0]                 sbox_in,
    input  logic [7:0]                 sbox_out,
    output logic [`AES_BLOCK_BITS-1:0] plain_out
);

    aes_state_u state;
    aes_state_u added;
    aes_state_u shifted;
    aes_state_u mixed;

    // multiply by x in GF(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // fixed multiples used by the inverse mix matrix
    function automatic logic [7:0] mul9(input logic [7:0] a);
        logic [7:0] a2;
        logic [7:0] a4;
        logic [7:0] a8;
        a2 = xtime(a);
        a4 = xtime(a2);
        a8 = xtime(a4);
        return a8 ^ a;
    endfunction

    function automatic logic [7:0] mul11(input logic [7:0] a);
        logic [7:0] a2;
        logic [7:0] a8;
        a2 = xtime(a);
        a8 = xtime(xtime(a2));
        return a8 ^ a2 ^ a;
    endfunction

    function automatic logic [7:0] mul13(input logic [7:0] a);
        logic [7:0] a4;
        logic [7:0] a8;
        a4 = xtime(xtime(a));
        a8 = xtime(a4);
        return a8 ^ a4 ^ a;
    endfunction

    function automatic logic [7:0] mul14(input logic [7:0] a);
        logic [7:0] a2;
        logic [7:0] a4;
        logic [7:0] a8;
        a2 = xtime(a);
        a4 = xtime(a2);
        a8 = xtime(a4);
        return a8 ^ a4 ^ a2;
    endfunction

    // row r rotates right by r columns
    function automatic aes_state_u inv_shift_rows(input aes_state_u s);
        aes_state_u t;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                t.col[c][r] = s.col[(c + 4 - r) % 4][r];
        end
        return t;
    endfunction

    // each column times the {0e,0b,0d,09} circulant
    function automatic aes_state_u inv_mix_columns(input aes_state_u s);
        aes_state_u t;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                t.col[c][r] = mul14(s.col[c][r]) ^ mul11(s.col[c][(r + 1) % 4])
                            ^ mul13(s.col[c][(r + 2) % 4]) ^ mul9(s.col[c][(r + 3) % 4]);
        end
        return t;
    endfunction

    // key addition on whole-block view
    assign added.block = state.block ^ round_key;
    assign shifted     = inv_shift_rows(state);
    assign mixed       = inv_mix_columns(added);

    // byte select for the S-box, idle value 0
    assign sbox_in = ctrl.rd_en ? state.col[ctrl.rd_idx[3:2]][ctrl.rd_idx[1:0]] : 8'h00;

    // strobes are one-hot per cycle
    always_ff @(posedge clk)
    begin
        if (ctrl.load)
            state.block <= cipher_in ^ round_key;
        else if (ctrl.shift)
            state <= shifted;
        else if (ctrl.wr_en)
            state.col[ctrl.wr_idx[3:2]][ctrl.wr_idx[1:0]] <= sbox_out;
        else if (ctrl.ark)
            state <= ctrl.mix ? mixed : added;
    end

    // plaintext held until the next final ark
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            plain_out <= '0;
        else if (ctrl.ark && !ctrl.mix)
            plain_out <= added.block;
    end

endmodule

/* src/dec_round_ctrl.sv */
// dec_round_ctrl: round FSM, descending key address, byte counters and datapath strobes
`timescale 1ns/1ps
`include "aes_defs.svh"

module dec_round_ctrl
    import aes_pkg::*;
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          start,
    output logic [`AES_KEY_ADDR_BITS-1:0] key_addr,
    output path_ctrl_t                    path_ctrl,
    output logic                          done
);

    // key index used while idle, i.e. the initial key addition
    localparam logic [`AES_KEY_ADDR_BITS-1:0] IDLE_ROUND  = `AES_ROUNDS;
    localparam logic [`AES_KEY_ADDR_BITS-1:0] FIRST_ROUND = `AES_ROUNDS - 1;
    // last sub cycle only collects the final S-box result
    localparam logic [4:0]                    SUB_LAST    = `AES_BLOCK_BYTES;

    typedef enum logic [1:0]
    {
        PH_IDLE,
        PH_SHIFT,
        PH_SUB,
        PH_ARK
    } phase_e;

    phase_e                         phase;
    logic [`AES_KEY_ADDR_BITS-1:0]  round;
    logic [4:0]                     byte_cnt;
    logic                           rd_en;
    logic                           rd_en_q;
    logic [3:0]                     rd_idx_q;
    logic                           last_ark;

    // reads on sub cycles 1..16, nothing issued on cycle 17
    assign rd_en    = (phase == PH_SUB) && (byte_cnt < SUB_LAST);
    // round 0 ark, no mix, produces the plaintext
    assign last_ark = (phase == PH_ARK) && (round == '0);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            phase    <= PH_IDLE;
            round    <= IDLE_ROUND;
            byte_cnt <= '0;
            rd_en_q  <= 1'b0;
            rd_idx_q <= '0;
            done     <= 1'b0;
        end
        else
        begin
            // write-back trails the read by the S-box register
            rd_en_q  <= rd_en;
            rd_idx_q <= byte_cnt[3:0];
            done     <= last_ark;
            case (phase)
                PH_IDLE:
                begin
                    // start while busy never reaches here
                    if (start)
                    begin
                        phase <= PH_SHIFT;
                        round <= FIRST_ROUND;
                    end
                end
                PH_SHIFT:
                begin
                    phase    <= PH_SUB;
                    byte_cnt <= '0;
                end
                PH_SUB:
                begin
                    if (byte_cnt == SUB_LAST)
                        phase <= PH_ARK;
                    else
                        byte_cnt <= byte_cnt + 5'd1;
                end
                PH_ARK:
                begin
                    if (round == '0)
                    begin
                        phase <= PH_IDLE;
                        round <= IDLE_ROUND;
                    end
                    else
                    begin
                        phase <= PH_SHIFT;
                        round <= round - 1'b1;
                    end
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // key index follows the round, 14 when idle
    assign key_addr = round;

    always_comb
    begin
        path_ctrl.load   = (phase == PH_IDLE) && start;
        path_ctrl.shift  = (phase == PH_SHIFT);
        path_ctrl.rd_en  = rd_en;
        path_ctrl.rd_idx = byte_cnt[3:0];
        path_ctrl.wr_en  = rd_en_q;
        path_ctrl.wr_idx = rd_idx_q;
        path_ctrl.ark    = (phase == PH_ARK);
        // mix columns skipped in the final round
        path_ctrl.mix    = (phase == PH_ARK) && !last_ark;
    end

endmodule

/* src/inv_sbox.sv */
// inv_sbox: inverse affine transform, GF(2^8) inverse by x^254, registered byte output
`timescale 1ns/1ps

module inv_sbox
(
    input  logic       clk,
    input  logic       resetn,
    input  logic [7:0] byte_in,
    output logic [7:0] byte_out
);

    logic [7:0] affine;
    logic [7:0] inverse;

    // GF(2^8) product modulo x^8+x^4+x^3+x+1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] acc;
        p   = 8'h00;
        acc = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ acc;
            acc = {acc[6:0], 1'b0} ^ (acc[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // square-and-multiply over exponent 254, msb first
    // zero stays zero since every step is a product
    function automatic logic [7:0] gf_inv(input logic [7:0] x);
        logic [7:0] acc;
        logic [7:0] e;
        acc = 8'h01;
        e   = 8'd254;
        for (int i = 7; i >= 0; i--)
        begin
            acc = gf_mul(acc, acc);
            if (e[i])
                acc = gf_mul(acc, x);
        end
        return acc;
    endfunction

    // inverse affine: rotl 1, 3, 6 then xor 05
    assign affine = {byte_in[6:0], byte_in[7]}
                  ^ {byte_in[4:0], byte_in[7:5]}
                  ^ {byte_in[1:0], byte_in[7:2]}
                  ^ 8'h05;

    assign inverse = gf_inv(affine);

    // lookup register, one cycle latency
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            byte_out <= 8'h00;
        else
            byte_out <= inverse;
    end

endmodule

/* src/aes_pkg.sv */
// aes_pkg: block state union, caller port structs and controller-to-datapath strobes
package aes_pkg;

`include "aes_defs.svh"

    // one block, viewed whole or as four columns of four bytes
    // col[c][r] is byte 4c+r, byte 0 in bits 127:120
    typedef union packed
    {
        logic [`AES_BLOCK_BITS-1:0] block;
        logic [0:3][0:3][7:0]       col;
    } aes_state_u;

    // caller request: start strobe plus ciphertext
    typedef struct packed
    {
        logic                       start;
        logic [`AES_BLOCK_BITS-1:0] block;
    } dec_in_t;

    // core response: done strobe plus plaintext
    typedef struct packed
    {
        logic                       done;
        logic [`AES_BLOCK_BITS-1:0] block;
    } dec_out_t;

    // per-cycle datapath commands
    typedef struct packed
    {
        logic       load;
        logic       shift;
        logic       rd_en;
        logic [3:0] rd_idx;
        logic       wr_en;
        logic [3:0] wr_idx;
        logic       ark;
        logic       mix;
    } path_ctrl_t;

endpackage

/* src/aes_defs.svh */
// AES-256 decryption core sizing macros: round count, block width, byte count, key address width
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// inverse cipher rounds for a 256-bit key
`define AES_ROUNDS 14

// one cipher block
`define AES_BLOCK_BITS 128

// bytes per block, one substitution per byte
`define AES_BLOCK_BYTES 16

// round key index 0..14
`define AES_KEY_ADDR_BITS 4

`endif
